// File: Bender.yml
package:
  name: dmem_unit

sources:
  - rtl/addr_map_pkg.sv
  - rtl/dcache_pkg.sv
  - rtl/addr_xlate.sv
  - rtl/dcache_lookup.sv
  - rtl/dbus_master.sv
  - rtl/dmem_unit.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/wb_mem_model.sv
      - sim/dmem_unit_asserts.sv
      - sim/dmem_unit_tb.sv

// File: project.f
rtl/addr_map_pkg.sv
rtl/dcache_pkg.sv
rtl/addr_xlate.sv
rtl/dcache_lookup.sv
rtl/dbus_master.sv
rtl/dmem_unit.sv
sim/tb_clkgen.sv
sim/wb_mem_model.sv
sim/dmem_unit_asserts.sv
sim/dmem_unit_tb.sv

// File: rtl/addr_map_pkg.sv
package addr_map_pkg;

    // fixed MIPS segment map, no TLB
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;
    localparam logic [31:0] KSEG1_BASE = 32'hA000_0000;

    // top address bits that pick the segment
    localparam int SEG_SEL_BITS = 3;

    // kseg0 and kseg1 both map to physical by clearing the segment bits
    localparam logic [31:0] PHYS_MASK = 32'h1FFF_FFFF;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

endpackage

// File: rtl/addr_xlate.sv
`timescale 1ns/100ps

module addr_xlate
    import addr_map_pkg::*;
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   req_i,
    input  logic   we_i,
    input  sel_t   sel_i,
    input  vaddr_t vaddr_i,
    input  word_t  wdata_i,
    input  logic   stall_i,
    output logic   s1_valid_o,
    output logic   s1_we_o,
    output logic   s1_cached_o,
    output logic   s1_err_o,
    output sel_t   s1_sel_o,
    output paddr_t s1_paddr_o,
    output word_t  s1_wdata_o
);

    logic [SEG_SEL_BITS-1:0] seg;
    logic                    in_kseg0;
    logic                    in_kseg1;
    logic                    accept;

    assign seg      = vaddr_i[31 -: SEG_SEL_BITS];
    assign in_kseg0 = (seg == KSEG0_BASE[31 -: SEG_SEL_BITS]);
    assign in_kseg1 = (seg == KSEG1_BASE[31 -: SEG_SEL_BITS]);
    assign accept   = req_i && !stall_i;

    // slot holds while the lookup stage waits on the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else if (!stall_i) begin
            s1_valid_o <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_we_o     <= we_i;
            s1_sel_o    <= sel_i;
            s1_wdata_o  <= wdata_i;
            s1_paddr_o  <= vaddr_i & PHYS_MASK;
            s1_cached_o <= in_kseg0;
            // useg and kseg2/3 are not mapped here
            s1_err_o    <= !(in_kseg0 || in_kseg1);
        end
    end

endmodule

// File: rtl/dbus_master.sv
`timescale 1ns/100ps

module dbus_master
    import addr_map_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       bus_req_i,
    input  bus_op_t    bus_op_i,
    input  paddr_t     bus_addr_i,
    input  sel_t       bus_sel_i,
    input  word_t      bus_wdata_i,
    input  word_t      wb_dat_i,
    input  logic       wb_ack_i,
    output logic       fill_valid_o,
    output logic [1:0] fill_word_idx_o,
    output word_t      fill_data_o,
    output word_t      bus_rdata_o,
    output logic       bus_done_o,
    output logic       wb_cyc_o,
    output logic       wb_stb_o,
    output logic       wb_we_o,
    output paddr_t     wb_adr_o,
    output sel_t       wb_sel_o,
    output word_t      wb_dat_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_GAP
    } state_t;

    state_t     state;
    bus_op_t    op_q;
    logic [1:0] word_cnt;
    logic       start;
    logic       ack_word;
    logic       last_word;

    // request stays high during the done pulse, so skip that cycle
    assign start     = (state == ST_IDLE) && bus_req_i && !bus_done_o;
    assign ack_word  = (state == ST_STROBE) && wb_ack_i;
    assign last_word = (op_q != OP_REFILL) || (word_cnt == 2'(LINE_WORDS - 1));

    assign bus_rdata_o = fill_data_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            wb_cyc_o     <= 1'b0;
            wb_stb_o     <= 1'b0;
            wb_we_o      <= 1'b0;
            word_cnt     <= '0;
            fill_valid_o <= 1'b0;
            bus_done_o   <= 1'b0;
        end else begin
            fill_valid_o <= 1'b0;
            bus_done_o   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_STROBE;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= (bus_op_i == OP_WRITE);
                        word_cnt <= '0;
                    end
                end
                ST_STROBE: begin
                    if (wb_ack_i) begin
                        wb_stb_o     <= 1'b0;
                        fill_valid_o <= (op_q == OP_REFILL);
                        bus_done_o   <= last_word;
                        if (last_word) begin
                            wb_cyc_o <= 1'b0;
                            wb_we_o  <= 1'b0;
                            state    <= ST_IDLE;
                        end else begin
                            word_cnt <= word_cnt + 2'd1;
                            state    <= ST_GAP;
                        end
                    end
                end
                // cyc held, stb low one cycle between refill words
                ST_GAP: begin
                    wb_stb_o <= 1'b1;
                    state    <= ST_STROBE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q     <= bus_op_i;
            wb_adr_o <= bus_addr_i;
            wb_sel_o <= (bus_op_i == OP_REFILL) ? 4'hF : bus_sel_i;
            wb_dat_o <= bus_wdata_i;
        end else if (ack_word) begin
            fill_data_o     <= wb_dat_i;
            fill_word_idx_o <= word_cnt;
            if (!last_word) begin
                wb_adr_o <= wb_adr_o + 32'd4;
            end
        end
    end

endmodule

// File: rtl/dcache_lookup.sv
`timescale 1ns/100ps

module dcache_lookup
    import addr_map_pkg::*;
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    s1_valid_i,
    input  logic    s1_we_i,
    input  logic    s1_cached_i,
    input  logic    s1_err_i,
    input  sel_t    s1_sel_i,
    input  paddr_t  s1_paddr_i,
    input  word_t   s1_wdata_i,
    input  logic    fill_valid_i,
    input  logic [1:0] fill_word_idx_i,
    input  word_t   fill_data_i,
    input  word_t   bus_rdata_i,
    input  logic    bus_done_i,
    output logic    stall_o,
    output logic    rvalid_o,
    output logic    err_o,
    output word_t   rdata_o,
    output logic    bus_req_o,
    output bus_op_t bus_op_o,
    output paddr_t  bus_addr_o,
    output sel_t    bus_sel_o,
    output word_t   bus_wdata_o
);

    logic [TAG_BITS-1:0] tag_mem [2**INDEX_BITS];
    word_t               data_mem [2**INDEX_BITS][LINE_WORDS];
    logic [2**INDEX_BITS-1:0] valid_q;

    logic [INDEX_BITS-1:0]    idx;
    logic [TAG_BITS-1:0]      tag;
    logic [OFFSET_BITS-3:0]   word_idx;
    logic                     hit;
    logic                     need_bus;
    logic                     done_q;
    logic                     hit_result;
    logic                     err_result;
    logic                     unc_result;
    word_t                    hit_word;

    assign idx      = s1_paddr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag      = s1_paddr_i[31 -: TAG_BITS];
    assign word_idx = s1_paddr_i[OFFSET_BITS-1:2];
    assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
    assign hit_word = data_mem[idx][word_idx];

    // stores always go out, loads only on a miss or when uncached
    assign need_bus = s1_valid_i && !s1_err_i && (s1_we_i || !s1_cached_i || !hit);
    assign stall_o  = need_bus && !done_q;

    assign bus_req_o   = stall_o;
    assign bus_op_o    = s1_we_i ? OP_WRITE : (s1_cached_i ? OP_REFILL : OP_READ);
    assign bus_addr_o  = (bus_op_o == OP_REFILL) ?
                         {s1_paddr_i[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}} : s1_paddr_i;
    assign bus_sel_o   = s1_sel_i;
    assign bus_wdata_o = s1_wdata_i;

    assign err_result = s1_valid_i && s1_err_i;
    assign hit_result = s1_valid_i && !s1_err_i && !s1_we_i && s1_cached_i && hit;
    assign unc_result = bus_done_i && (bus_op_o == OP_READ);

    // marks the frozen item as served for one cycle after bus_done
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (bus_done_i) begin
            done_q <= 1'b1;
        end else if (!stall_o) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (bus_done_i && (bus_op_o == OP_REFILL)) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_done_i && (bus_op_o == OP_REFILL)) begin
            tag_mem[idx] <= tag;
        end
    end

    // refill words, then byte merge for a store that hit
    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            data_mem[idx][fill_word_idx_i] <= fill_data_i;
        end else if (bus_done_i && s1_we_i && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (s1_sel_i[b]) begin
                    data_mem[idx][word_idx][8*b +: 8] <= s1_wdata_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            rvalid_o <= err_result || hit_result || unc_result;
            err_o    <= err_result;
        end
    end

    always_ff @(posedge clk) begin
        rdata_o <= unc_result ? bus_rdata_i : hit_word;
    end

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;

    // direct mapped, 16 lines of 4 words
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = 24;

    // operations handed from the lookup stage to the bus master
    typedef enum logic [1:0] {
        OP_REFILL,
        OP_READ,
        OP_WRITE
    } bus_op_t;

endpackage

// File: rtl/dmem_unit.sv
`timescale 1ns/100ps

module dmem_unit
    import addr_map_pkg::*;
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   req_i,
    input  logic   we_i,
    input  sel_t   sel_i,
    input  vaddr_t vaddr_i,
    input  word_t  wdata_i,
    output logic   stall_o,
    output logic   rvalid_o,
    output word_t  rdata_o,
    output logic   err_o,
    output logic   wb_cyc_o,
    output logic   wb_stb_o,
    output logic   wb_we_o,
    output paddr_t wb_adr_o,
    output sel_t   wb_sel_o,
    output word_t  wb_dat_o,
    input  word_t  wb_dat_i,
    input  logic   wb_ack_i
);

    logic       s1_valid;
    logic       s1_we;
    logic       s1_cached;
    logic       s1_err;
    sel_t       s1_sel;
    paddr_t     s1_paddr;
    word_t      s1_wdata;

    logic       bus_req;
    bus_op_t    bus_op;
    paddr_t     bus_addr;
    sel_t       bus_sel;
    word_t      bus_wdata;
    logic       fill_valid;
    logic [1:0] fill_word_idx;
    word_t      fill_data;
    word_t      bus_rdata;
    logic       bus_done;

    addr_xlate u_addr_xlate (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .we_i        (we_i),
        .sel_i       (sel_i),
        .vaddr_i     (vaddr_i),
        .wdata_i     (wdata_i),
        .stall_i     (stall_o),
        .s1_valid_o  (s1_valid),
        .s1_we_o     (s1_we),
        .s1_cached_o (s1_cached),
        .s1_err_o    (s1_err),
        .s1_sel_o    (s1_sel),
        .s1_paddr_o  (s1_paddr),
        .s1_wdata_o  (s1_wdata)
    );

    dcache_lookup u_dcache_lookup (
        .clk             (clk),
        .rst             (rst),
        .s1_valid_i      (s1_valid),
        .s1_we_i         (s1_we),
        .s1_cached_i     (s1_cached),
        .s1_err_i        (s1_err),
        .s1_sel_i        (s1_sel),
        .s1_paddr_i      (s1_paddr),
        .s1_wdata_i      (s1_wdata),
        .fill_valid_i    (fill_valid),
        .fill_word_idx_i (fill_word_idx),
        .fill_data_i     (fill_data),
        .bus_rdata_i     (bus_rdata),
        .bus_done_i      (bus_done),
        .stall_o         (stall_o),
        .rvalid_o        (rvalid_o),
        .err_o           (err_o),
        .rdata_o         (rdata_o),
        .bus_req_o       (bus_req),
        .bus_op_o        (bus_op),
        .bus_addr_o      (bus_addr),
        .bus_sel_o       (bus_sel),
        .bus_wdata_o     (bus_wdata)
    );

    dbus_master u_dbus_master (
        .clk             (clk),
        .rst             (rst),
        .bus_req_i       (bus_req),
        .bus_op_i        (bus_op),
        .bus_addr_i      (bus_addr),
        .bus_sel_i       (bus_sel),
        .bus_wdata_i     (bus_wdata),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_i        (wb_ack_i),
        .fill_valid_o    (fill_valid),
        .fill_word_idx_o (fill_word_idx),
        .fill_data_o     (fill_data),
        .bus_rdata_o     (bus_rdata),
        .bus_done_o      (bus_done),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_we_o         (wb_we_o),
        .wb_adr_o        (wb_adr_o),
        .wb_sel_o        (wb_sel_o),
        .wb_dat_o        (wb_dat_o)
    );

endmodule

// File: sim/dmem_unit_asserts.sv
`timescale 1ns/100ps

module dmem_unit_asserts (
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc_o,
    input logic        wb_stb_o,
    input logic        wb_we_o,
    input logic [31:0] wb_adr_o,
    input logic [3:0]  wb_sel_o,
    input logic [31:0] wb_dat_o,
    input logic        wb_ack_i,
    input logic        rvalid_o,
    input logic        err_o
);

    assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o)
        else $error("wb_stb_o high without wb_cyc_o");

    // request fields frozen until the slave acks
    assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && !wb_ack_i) |=> ($stable(wb_adr_o) && $stable(wb_we_o)
            && $stable(wb_sel_o) && $stable(wb_dat_o)))
        else $error("wishbone request changed before ack");

    assert property (@(posedge clk) disable iff (rst) err_o |-> rvalid_o)
        else $error("err_o high without rvalid_o");

    assert property (@(posedge clk) rst |=> !wb_cyc_o)
        else $error("wb_cyc_o high during reset");

endmodule

bind dmem_unit dmem_unit_asserts u_dmem_unit_asserts (.*);

// File: sim/dmem_unit_tb.sv
`timescale 1ns/100ps

module dmem_unit_tb
    import addr_map_pkg::*;
    import dcache_pkg::*;
;

    typedef struct packed {
        logic        we;
        logic [31:0] vaddr;
        logic [3:0]  sel;
        logic [31:0] wdata;
        logic        exp_err;
        logic        chain;
        logic [2:0]  exp_bus;
        logic [2:0]  exp_lat;
    } entry_t;

    localparam int NUM = 19;
    localparam int WATCHDOG_NS = (NUM * (LINE_WORDS * 6 + 8) + 8) * 10;
    localparam logic [31:0] SEED = 32'hbf58_31d0;

    // we, vaddr, sel, wdata, expect_err, chain next, bus cycles, latency (0 = any)
    entry_t stim [NUM] = '{
        '{1'b0, 32'h8000_0100, 4'hf, 32'h0,         1'b0, 1'b0, 3'd4, 3'd0},
        '{1'b0, 32'h8000_0104, 4'hf, 32'h0,         1'b0, 1'b1, 3'd0, 3'd2},
        '{1'b0, 32'h8000_0108, 4'hf, 32'h0,         1'b0, 1'b0, 3'd0, 3'd2},
        '{1'b0, 32'h8000_010c, 4'hf, 32'h0,         1'b0, 1'b0, 3'd0, 3'd2},
        '{1'b1, 32'h8000_0104, 4'h6, 32'h1234_5678, 1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'h8000_0104, 4'hf, 32'h0,         1'b0, 1'b0, 3'd0, 3'd2},
        '{1'b0, 32'ha000_0104, 4'hf, 32'h0,         1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'ha000_0104, 4'hf, 32'h0,         1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'ha000_0200, 4'hf, 32'h0,         1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'h0000_0040, 4'hf, 32'h0,         1'b1, 1'b0, 3'd0, 3'd2},
        '{1'b1, 32'h0040_0000, 4'hf, 32'hdead_beef, 1'b1, 1'b0, 3'd0, 3'd2},
        '{1'b0, 32'hc000_0000, 4'hf, 32'h0,         1'b1, 1'b0, 3'd0, 3'd2},
        '{1'b1, 32'he000_1000, 4'h3, 32'h0bad_f00d, 1'b1, 1'b0, 3'd0, 3'd2},
        '{1'b0, 32'h8000_0100, 4'hf, 32'h0,         1'b0, 1'b0, 3'd0, 3'd2},
        '{1'b1, 32'h8000_0304, 4'h1, 32'h0000_00a5, 1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'h8000_0304, 4'hf, 32'h0,         1'b0, 1'b0, 3'd4, 3'd0},
        '{1'b0, 32'h8000_0104, 4'hf, 32'h0,         1'b0, 1'b0, 3'd4, 3'd0},
        '{1'b1, 32'ha000_0108, 4'h8, 32'h5a00_0000, 1'b0, 1'b0, 3'd1, 3'd0},
        '{1'b0, 32'h8000_0108, 4'hf, 32'h0,         1'b0, 1'b0, 3'd0, 3'd2}
    };

    logic   clk;
    logic   rst;
    logic   req_i;
    logic   we_i;
    sel_t   sel_i;
    vaddr_t vaddr_i;
    word_t  wdata_i;
    logic   stall_o;
    logic   rvalid_o;
    word_t  rdata_o;
    logic   err_o;
    logic   wb_cyc_o;
    logic   wb_stb_o;
    logic   wb_we_o;
    paddr_t wb_adr_o;
    sel_t   wb_sel_o;
    word_t  wb_dat_o;
    word_t  wb_dat_i;
    logic   wb_ack_i;

    word_t  shadow [logic [29:0]];
    logic   exp_err_q [$];
    word_t  exp_data_q [$];
    int     exp_acc_q [$];
    int     exp_lat_q [$];
    paddr_t mon_adr [$];
    logic   mon_we [$];
    sel_t   mon_sel [$];
    word_t  mon_dat [$];
    int     cyc_cnt = 0;
    logic   e_err;
    word_t  e_data;
    int     e_acc;
    int     e_lat;

    tb_clkgen u_clkgen (.clk_o(clk));

    dmem_unit u_dmem_unit (.*);

    wb_mem_model #(.SEED(SEED)) u_mem (
        .clk   (clk),
        .rst   (rst),
        .cyc_i (wb_cyc_o),
        .stb_i (wb_stb_o),
        .we_i  (wb_we_o),
        .adr_i (wb_adr_o),
        .sel_i (wb_sel_o),
        .dat_i (wb_dat_o),
        .dat_o (wb_dat_i),
        .ack_o (wb_ack_i)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // kseg0 and kseg1 both drop the top three bits
    function automatic paddr_t phys_addr(input vaddr_t va);
        return {3'b000, va[28:0]};
    endfunction

    function automatic word_t shadow_read(input logic [29:0] a);
        return shadow.exists(a) ? shadow[a] : ({2'b00, a} ^ 32'hc0de_0000);
    endfunction

    task automatic drive_entry(input int i);
        req_i   <= 1'b1;
        we_i    <= stim[i].we;
        sel_i   <= stim[i].sel;
        vaddr_i <= stim[i].vaddr;
        wdata_i <= stim[i].wdata;
    endtask

    // returns at the negedge before the accepting edge
    task automatic wait_accept(input int i);
        logic [29:0] a;
        paddr_t      pa;
        word_t       w;
        pa = phys_addr(stim[i].vaddr);
        a  = pa[31:2];
        forever begin
            @(negedge clk);
            if (!stall_o) break;
        end
        if (!stim[i].we || stim[i].exp_err) begin
            exp_err_q.push_back(stim[i].exp_err);
            exp_data_q.push_back(shadow_read(a));
            exp_acc_q.push_back(cyc_cnt);
            exp_lat_q.push_back(stim[i].exp_lat);
        end else begin
            w = shadow_read(a);
            for (int b = 0; b < 4; b++) begin
                if (stim[i].sel[b]) w[8*b +: 8] = stim[i].wdata[8*b +: 8];
            end
            shadow[a] = w;
        end
    endtask

    task automatic wait_complete(input int i);
        if (stim[i].we && !stim[i].exp_err) begin
            @(negedge clk);
            while (stall_o) @(negedge clk);
        end else begin
            while (exp_err_q.size() != 0) @(negedge clk);
        end
    endtask

    task automatic check_bus(input int i, input int start, input int expected);
        paddr_t pa;
        paddr_t base;
        word_t  mask;
        pa   = phys_addr(stim[i].vaddr);
        base = pa & ~paddr_t'(LINE_WORDS * 4 - 1);
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{stim[i].sel[b]}};
        end
        assert (mon_adr.size() - start == expected) else
            report_failure($sformatf("mismatch bus cycle count: got %h expected %h",
                mon_adr.size() - start, expected));
        if (expected == LINE_WORDS) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                assert (mon_adr[start+k] == base + 4 * k && !mon_we[start+k]) else
                    report_failure($sformatf("mismatch wb_adr_o: got %h expected %h",
                        mon_adr[start+k], base + 4 * k));
            end
        end else if (expected == 1) begin
            assert (mon_adr[start] == pa && mon_we[start] == stim[i].we) else
                report_failure($sformatf("mismatch wb_adr_o: got %h expected %h",
                    mon_adr[start], pa));
            assert (!stim[i].we || mon_sel[start] == stim[i].sel) else
                report_failure($sformatf("mismatch wb_sel_o: got %h expected %h",
                    mon_sel[start], stim[i].sel));
            assert (!stim[i].we || (mon_dat[start] & mask) == (stim[i].wdata & mask)) else
                report_failure($sformatf("mismatch wb_dat_o: got %h expected %h",
                    mon_dat[start] & mask, stim[i].wdata & mask));
        end
    endtask

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // acked bus cycles
    always @(posedge clk) begin
        if (!rst && wb_cyc_o && wb_stb_o && wb_ack_i) begin
            mon_adr.push_back(wb_adr_o);
            mon_we.push_back(wb_we_o);
            mon_sel.push_back(wb_sel_o);
            mon_dat.push_back(wb_dat_o);
        end
    end

    always @(negedge clk) begin
        if (!rst && rvalid_o) begin
            assert (exp_err_q.size() != 0) else
                report_failure("rvalid_o raised with no load outstanding");
            e_err  = exp_err_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_acc  = exp_acc_q.pop_front();
            e_lat  = exp_lat_q.pop_front();
            assert (err_o == e_err) else
                report_failure($sformatf("mismatch err_o: got %h expected %h", err_o, e_err));
            assert (e_err || rdata_o == e_data) else
                report_failure($sformatf("mismatch rdata_o: got %h expected %h",
                    rdata_o, e_data));
            assert (e_lat == 0 || cyc_cnt - e_acc == e_lat) else
                report_failure($sformatf("mismatch rvalid_o latency: got %h expected %h",
                    cyc_cnt - e_acc, e_lat));
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the DUT stopped answering");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin : main
        int start;
        int grp_exp;
        rst     = 1'b1;
        req_i   = 1'b0;
        we_i    = 1'b0;
        sel_i   = '0;
        vaddr_i = '0;
        wdata_i = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!stall_o && !rvalid_o && !wb_cyc_o) else
            report_failure("outputs not idle after reset");
        @(posedge clk);
        start   = mon_adr.size();
        grp_exp = 0;
        drive_entry(0);
        for (int i = 0; i < NUM; i++) begin
            wait_accept(i);
            grp_exp += stim[i].exp_bus;
            @(posedge clk);
            if (stim[i].chain && i + 1 < NUM) begin
                // next request goes in on the following edge
                drive_entry(i + 1);
            end else begin
                req_i <= 1'b0;
                wait_complete(i);
                check_bus(i, start, grp_exp);
                @(posedge clk);
                start   = mon_adr.size();
                grp_exp = 0;
                if (i + 1 < NUM) drive_entry(i + 1);
            end
        end
        repeat (4) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: sim/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem [logic [29:0]];
    integer      seed;
    logic        busy;
    int          cnt;

    initial begin
        seed = SEED;
    end

    // untouched words read as their word address xor a marker
    function automatic logic [31:0] read_word(input logic [29:0] a);
        return mem.exists(a) ? mem[a] : ({2'b00, a} ^ 32'hc0de_0000);
    endfunction

    always @(posedge clk) begin : slave
        int          waits;
        logic [31:0] word;
        if (rst) begin
            ack_o <= 1'b0;
            busy  <= 1'b0;
            cnt   <= 0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o) begin
                waits = 0;
                if (!busy) begin
                    waits = $random(seed) & 3;
                    cnt   <= waits;
                    busy  <= (waits != 0);
                end else if (cnt > 1) begin
                    cnt   <= cnt - 1;
                    waits = 1;
                end
                if (waits == 0) begin
                    busy  <= 1'b0;
                    ack_o <= 1'b1;
                    word  = read_word(adr_i[31:2]);
                    dat_o <= word;
                    if (we_i) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel_i[b]) begin
                                word[8*b +: 8] = dat_i[8*b +: 8];
                            end
                        end
                        mem[adr_i[31:2]] = word;
                    end
                end
            end
        end
    end

endmodule
